// ==== files.f ====
+incdir+source
source/dcache_pkg.sv
source/cache_array.sv
source/way_select.sv
source/dcache_control.sv
source/access_datapath.sv
source/dcache_top.sv
tb/mem_model.sv
tb/dcache_tb.sv

// ==== tb/dcache_tb.sv ====
`default_nettype none

`include "dcache_macros.svh"

module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import dcache_pkg::*;

    localparam int wait_limit = 1000;
    localparam int mem_words  = 16384;

    typedef struct packed {
        logic  is_load;
        addr_t addr;
        word_t expected;
    } pending_t;

    logic       clk;
    logic       resetn;
    dbus_req_t  dreq;
    dbus_resp_t dresp;
    cbus_req_t  creq;
    cbus_resp_t cresp;

    word_t      shadow [mem_words];
    pending_t   pending [$];
    int         errors;
    int         checks;
    integer     seed;
    logic       addr_ok_q;

    dcache_top uut (
        .clk    (clk),
        .resetn (resetn),
        .dreq   (dreq),
        .dresp  (dresp),
        .creq   (creq),
        .cresp  (cresp)
    );

    mem_model mem (
        .clk    (clk),
        .resetn (resetn),
        .creq   (creq),
        .cresp  (cresp)
    );

    always #5 clk = ~clk;

    // same pattern the memory model starts from
    function automatic word_t pattern_word(input int unsigned slot);
        logic [31:0] a;
        a = slot << 2;
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic word_t merge(input word_t old, input word_t data, input strobe_t strobe);
        word_t r;
        r = old;
        for (int b = 0; b < `DC_WORD_BYTES; b++) begin
            if (strobe[b]) begin
                r[8*b +: 8] = data[8*b +: 8];
            end
        end
        return r;
    endfunction

    function automatic word_t expected_load(input addr_t a);
        return shadow[a[15:2]];
    endfunction

    function automatic addr_t make_addr(input int tag, input int index, input int offset);
        addr_t a;
        a        = '0;
        a.tag    = tag_t'(tag);
        a.index  = index_t'(index);
        a.offset = offset_t'(offset);
        return a;
    endfunction

    // present a request and hold it until it is accepted
    task automatic access(input addr_t addr, input strobe_t strobe, input word_t data,
                          output int cycles);
        pending_t p;
        bit       accepted;
        dreq     <= {1'b1, addr, strobe, data};
        cycles   = 0;
        accepted = 1'b0;
        while (!accepted && cycles < wait_limit) begin
            @(posedge clk);
            cycles++;
            accepted = dresp.addr_ok;
        end
        if (accepted) begin
            if (strobe != '0) begin
                shadow[addr[15:2]] = merge(shadow[addr[15:2]], data, strobe);
            end
            p.is_load  = (strobe == '0);
            p.addr     = addr;
            p.expected = expected_load(addr);
            pending.push_back(p);
        end else begin
            $display("timeout: request to %h was not accepted in %0d cycles", addr, wait_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    endtask

    task automatic drain();
        int waited;
        dreq.valid <= 1'b0;
        waited = 0;
        while (pending.size() != 0 && waited < wait_limit) begin
            @(posedge clk);
            waited++;
        end
        if (pending.size() != 0) begin
            $display("timeout: %0d accesses never saw data_ok", pending.size());
            $display("STATUS: FAIL");
            $finish;
        end
    endtask

    // data_ok must follow each accept by one cycle
    always @(posedge clk) begin
        pending_t p;
        if (resetn) begin
            addr_ok_q <= 1'b0;
        end else begin
            addr_ok_q <= dresp.addr_ok;
            if (dresp.data_ok !== addr_ok_q) begin
                errors++;
                $display("Error at %0t: data_ok is %b after addr_ok %b", $time,
                         dresp.data_ok, addr_ok_q);
            end
            if (dresp.data_ok === 1'b1) begin
                if (pending.size() == 0) begin
                    errors++;
                    $display("Error at %0t: data_ok with no access outstanding", $time);
                end else begin
                    p = pending.pop_front();
                    if (p.is_load) begin
                        checks++;
                        if (dresp.data !== p.expected) begin
                            errors++;
                            $display("Error at %0t: load %h returned %h, expected %h", $time,
                                     p.addr, dresp.data, p.expected);
                        end
                    end
                end
            end
        end
    end

    initial begin
        addr_t   a;
        strobe_t strobe;
        int      cycles;
        clk    = 1'b0;
        resetn = 1'b1;
        dreq   = '0;
        errors = 0;
        checks = 0;
        seed   = 22009;
        for (int i = 0; i < mem_words; i++) begin
            shadow[i] = pattern_word(i);
        end

        repeat (5) @(posedge clk);
        resetn <= 1'b0;

        // quiet after reset while nothing is requested
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            checks++;
            if (dresp.addr_ok !== 1'b0 || dresp.data_ok !== 1'b0 || creq.valid !== 1'b0) begin
                errors++;
                $display("Error at %0t: handshake active with no request", $time);
            end
        end

        // load miss, then a hit in the same line
        access(make_addr(0, 1, 0), 4'b0000, '0, cycles);
        access(make_addr(0, 1, 1), 4'b0000, '0, cycles);
        checks++;
        if (cycles != 1) begin
            errors++;
            $display("Error at %0t: hit took %0d cycles to accept", $time, cycles);
        end

        // partial store, then read it back
        access(make_addr(0, 1, 2), 4'b0110, 32'hdead_beef, cycles);
        access(make_addr(0, 1, 2), 4'b0000, '0, cycles);

        // three lines in set 5 force dirty evictions
        for (int t = 1; t <= 3; t++) begin
            access(make_addr(t, 5, 3), 4'b1111, 32'hc0de_0000 + t, cycles);
        end
        access(make_addr(1, 5, 3), 4'b0000, '0, cycles);
        drain();
        for (int t = 1; t <= 2; t++) begin
            a = make_addr(t, 5, 0);
            for (int w = 0; w < `DC_LINE_WORDS; w++) begin
                checks++;
                if (mem.words[a[15:2] + w] !== shadow[a[15:2] + w]) begin
                    errors++;
                    $display("Error at %0t: memory word %h holds %h, expected %h", $time,
                             (a[15:2] + w) << 2, mem.words[a[15:2] + w], shadow[a[15:2] + w]);
                end
            end
        end

        // random mix over four tags and four sets
        @(posedge clk);
        for (int n = 0; n < 400; n++) begin
            a = make_addr($random(seed) & 3, $random(seed) & 3, $random(seed) & 15);
            strobe = '0;
            if ($random(seed) & 1) begin
                strobe = strobe_t'($random(seed));
                if (strobe == '0) begin
                    strobe = 4'b1111;
                end
            end
            access(a, strobe, $random(seed), cycles);
        end
        drain();
        repeat (4) @(posedge clk);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/mem_model.sv ====
`default_nettype none

`include "dcache_macros.svh"

module mem_model (
    input  logic                   clk,
    input  logic                   resetn,
    input  dcache_pkg::cbus_req_t  creq,
    output dcache_pkg::cbus_resp_t cresp
);
    timeunit 1ns;
    timeprecision 1ps;
    import dcache_pkg::*;

    localparam int mem_words = 16384;

    word_t   words [mem_words];
    integer  seed;
    offset_t beat;
    logic    ready_q;
    logic    last_q;
    word_t   rd_word;

    // preload value from the full byte address
    function automatic word_t init_word(input int unsigned slot);
        logic [31:0] a;
        a = slot << 2;
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    initial begin
        seed    = 22009;
        ready_q = 1'b0;
        last_q  = 1'b0;
        beat    = '0;
        for (int i = 0; i < mem_words; i++) begin
            words[i] = init_word(i);
        end
    end

    // read word follows the beat address in the same cycle
    assign rd_word = creq.valid ? words[creq.addr[15:2]] : '0;
    assign cresp   = {ready_q, last_q, rd_word};

    always @(posedge clk) begin
        offset_t nb;
        if (resetn) begin
            ready_q <= 1'b0;
            last_q  <= 1'b0;
            beat    <= '0;
        end else begin
            nb = beat;
            // one word moves on each ready beat of a burst
            if (creq.valid && ready_q) begin
                if (creq.is_write) begin
                    words[creq.addr[15:2]] <= creq.data;
                end
                if (last_q) begin
                    nb = '0;
                end else begin
                    nb = beat + 1'b1;
                end
            end
            beat    <= nb;
            // ready about three beats in four
            ready_q <= (($random(seed) & 3) != 0);
            last_q  <= (nb == offset_t'(`DC_BURST_LEN - 1));
        end
    end

endmodule

`default_nettype wire

// ==== source/dcache_top.sv ====
`default_nettype none

`include "dcache_macros.svh"

module dcache_top (
    input  logic                   clk,
    input  logic                   resetn,
    input  dcache_pkg::dbus_req_t  dreq,
    output dcache_pkg::dbus_resp_t dresp,
    output dcache_pkg::cbus_req_t  creq,
    input  dcache_pkg::cbus_resp_t cresp
);
    import dcache_pkg::*;

    ctrl_t      ctrl;
    logic       hit;
    way_t       hit_way;
    way_t       victim_way;
    logic       victim_dirty;
    tag_t       victim_tag;
    logic       store_hit;
    logic       req_is_store;
    logic       addr_ok;
    logic       data_ok;
    logic       bus_valid;
    logic       bus_write;
    index_t     req_index;
    logic       tag_we;
    tag_pair_t  tag_wdata;
    tag_pair_t  tags;
    logic       data_we;
    data_addr_t data_waddr;
    word_t      data_wdata;
    data_addr_t data_raddr;
    word_t      data_rdata;
    word_t      resp_data;
    addr_t      bus_addr;
    word_t      bus_wdata;

    // any strobe bit makes it a store
    assign req_is_store = |dreq.strobe;
    assign req_index    = dreq.addr.index;

    assign dresp = '{addr_ok: addr_ok, data_ok: data_ok, data: resp_data};
    assign creq  = '{valid: bus_valid, is_write: bus_write, addr: bus_addr, data: bus_wdata};

    dcache_control control (
        .clk          (clk),
        .resetn       (resetn),
        .req_valid    (dreq.valid),
        .req_is_store (req_is_store),
        .hit          (hit),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .cresp_ready  (cresp.ready),
        .cresp_last   (cresp.last),
        .ctrl         (ctrl),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .bus_valid    (bus_valid),
        .bus_write    (bus_write),
        .store_hit    (store_hit)
    );

    way_select ways (
        .clk          (clk),
        .resetn       (resetn),
        .req_addr     (dreq.addr),
        .req_valid    (dreq.valid),
        .tags         (tags),
        .ctrl         (ctrl),
        .store_hit    (store_hit),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    access_datapath datapath (
        .clk        (clk),
        .resetn     (resetn),
        .dreq       (dreq),
        .ctrl       (ctrl),
        .store_hit  (store_hit),
        .hit_way    (hit_way),
        .victim_tag (victim_tag),
        .cresp_data (cresp.data),
        .tag_we     (tag_we),
        .tag_wdata  (tag_wdata),
        .tags       (tags),
        .data_we    (data_we),
        .data_waddr (data_waddr),
        .data_wdata (data_wdata),
        .data_raddr (data_raddr),
        .data_rdata (data_rdata),
        .resp_data  (resp_data),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata)
    );

    // one tag pair per set
    cache_array #(
        .elem_t (tag_pair_t),
        .depth  (`DC_SETS)
    ) tag_array (
        .clk   (clk),
        .we    (tag_we),
        .waddr (req_index),
        .wdata (tag_wdata),
        .raddr (req_index),
        .rdata (tags)
    );

    cache_array #(
        .elem_t (word_t),
        .depth  (`DC_WAYS * `DC_SETS * `DC_LINE_WORDS)
    ) data_array (
        .clk   (clk),
        .we    (data_we),
        .waddr (data_waddr),
        .wdata (data_wdata),
        .raddr (data_raddr),
        .rdata (data_rdata)
    );

endmodule

`default_nettype wire

// ==== source/access_datapath.sv ====
`default_nettype none

`include "dcache_macros.svh"

module access_datapath (
    input  logic                   clk,
    input  logic                   resetn,
    input  dcache_pkg::dbus_req_t  dreq,
    input  dcache_pkg::ctrl_t      ctrl,
    input  logic                   store_hit,
    input  dcache_pkg::way_t       hit_way,
    input  dcache_pkg::tag_t       victim_tag,
    input  dcache_pkg::word_t      cresp_data,
    output logic                   tag_we,
    output dcache_pkg::tag_pair_t  tag_wdata,
    input  dcache_pkg::tag_pair_t  tags,
    output logic                   data_we,
    output dcache_pkg::data_addr_t data_waddr,
    output dcache_pkg::word_t      data_wdata,
    output dcache_pkg::data_addr_t data_raddr,
    input  dcache_pkg::word_t      data_rdata,
    output dcache_pkg::word_t      resp_data,
    output dcache_pkg::addr_t      bus_addr,
    output dcache_pkg::word_t      bus_wdata
);
    import dcache_pkg::*;

    word_t      byte_mask;
    word_t      merged;
    data_addr_t hit_addr;
    data_addr_t line_addr;
    word_t      resp_q;

    // strobes widened to a bit mask
    always_comb begin
        for (int b = 0; b < `DC_WORD_BYTES; b++) begin
            byte_mask[8*b +: 8] = {8{dreq.strobe[b]}};
        end
    end

    // store bytes over the word already in the array
    assign merged = (dreq.data & byte_mask) | (data_rdata & ~byte_mask);

    assign hit_addr  = '{way: hit_way, index: dreq.addr.index, offset: dreq.addr.offset};
    assign line_addr = '{way: ctrl.way, index: dreq.addr.index, offset: ctrl.beat};

    // during a miss the array follows the burst beat
    assign data_raddr = (ctrl.mode == MODE_IDLE) ? hit_addr : line_addr;
    assign data_waddr = ctrl.fill ? line_addr : hit_addr;
    assign data_wdata = ctrl.fill ? cresp_data : merged;
    assign data_we    = store_hit || ctrl.fill;

    // new tag goes in with the last refill word
    assign tag_we = ctrl.fill && (ctrl.beat == offset_t'(`DC_BURST_LEN - 1));

    always_comb begin
        tag_wdata           = tags;
        tag_wdata[ctrl.way] = dreq.addr.tag;
    end

    // word address of the current beat
    always_comb begin
        bus_addr        = dreq.addr;
        bus_addr.offset = ctrl.beat;
        bus_addr.align  = '0;
        if (ctrl.mode == MODE_WRITEBACK) begin
            bus_addr.tag = victim_tag;
        end
    end

    assign bus_wdata = data_rdata;

    // load word for the data_ok cycle
    always_ff @(posedge clk) begin
        if (resetn) begin
            resp_q <= '0;
        end else begin
            resp_q <= data_rdata;
        end
    end

    assign resp_data = resp_q;

endmodule

`default_nettype wire

// ==== source/dcache_control.sv ====
`default_nettype none

module dcache_control (
    input  logic              clk,
    input  logic              resetn,
    input  logic              req_valid,
    input  logic              req_is_store,
    input  logic              hit,
    input  dcache_pkg::way_t  victim_way,
    input  logic              victim_dirty,
    input  logic              cresp_ready,
    input  logic              cresp_last,
    output dcache_pkg::ctrl_t ctrl,
    output logic              addr_ok,
    output logic              data_ok,
    output logic              bus_valid,
    output logic              bus_write,
    output logic              store_hit
);
    import dcache_pkg::*;

    mode_t   mode_q;
    way_t    way_q;
    offset_t beat_q;
    logic    data_ok_q;

    always_ff @(posedge clk) begin
        if (resetn) begin
            mode_q    <= MODE_IDLE;
            way_q     <= '0;
            beat_q    <= '0;
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= addr_ok;
            case (mode_q)
                MODE_IDLE: begin
                    // on a miss hold the victim way for the whole refill
                    if (req_valid && !hit) begin
                        way_q  <= victim_way;
                        beat_q <= '0;
                        if (victim_dirty) begin
                            mode_q <= MODE_WRITEBACK;
                        end else begin
                            mode_q <= MODE_FETCH;
                        end
                    end
                end
                MODE_WRITEBACK: begin
                    if (cresp_ready) begin
                        if (cresp_last) begin
                            beat_q <= '0;
                            mode_q <= MODE_FETCH;
                        end else begin
                            beat_q <= beat_q + 1'b1;
                        end
                    end
                end
                MODE_FETCH: begin
                    if (cresp_ready) begin
                        if (cresp_last) begin
                            beat_q <= '0;
                            mode_q <= MODE_IDLE;
                        end else begin
                            beat_q <= beat_q + 1'b1;
                        end
                    end
                end
                default: begin
                    mode_q <= MODE_IDLE;
                end
            endcase
        end
    end

    // accept only hits and only while no miss is in flight
    assign addr_ok   = (mode_q == MODE_IDLE) && req_valid && hit;
    assign store_hit = addr_ok && req_is_store;
    assign data_ok   = data_ok_q;

    // valid stays up for the whole burst
    assign bus_valid = (mode_q != MODE_IDLE);
    assign bus_write = (mode_q == MODE_WRITEBACK);

    always_comb begin
        ctrl.mode = mode_q;
        ctrl.way  = way_q;
        ctrl.beat = beat_q;
        // a refill word lands only on a ready beat
        ctrl.fill = (mode_q == MODE_FETCH) && cresp_ready;
    end

endmodule

`default_nettype wire

// ==== source/way_select.sv ====
`default_nettype none

`include "dcache_macros.svh"

module way_select (
    input  logic                  clk,
    input  logic                  resetn,
    input  dcache_pkg::addr_t     req_addr,
    input  logic                  req_valid,
    input  dcache_pkg::tag_pair_t tags,
    input  dcache_pkg::ctrl_t     ctrl,
    input  logic                  store_hit,
    output logic                  hit,
    output dcache_pkg::way_t      hit_way,
    output dcache_pkg::way_t      victim_way,
    output logic                  victim_dirty,
    output dcache_pkg::tag_t      victim_tag
);
    import dcache_pkg::*;

    logic [`DC_SETS-1:0][`DC_WAYS-1:0] valid_q;
    logic [`DC_SETS-1:0][`DC_WAYS-1:0] dirty_q;
    way_t [`DC_SETS-1:0]               plru_q;
    logic [`DC_WAYS-1:0]               match;
    index_t                            idx;
    logic                              fill_done;

    assign idx = req_addr.index;

    // tag compare across the ways of the set
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            match[w] = valid_q[idx][w] && (tags[w] == req_addr.tag);
            if (match[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit = req_valid && (|match);

    // plru bit names the way to replace next
    assign victim_way   = plru_q[idx];
    assign victim_dirty = valid_q[idx][victim_way] && dirty_q[idx][victim_way];

    // latched miss way selects the tag for the writeback address
    assign victim_tag = tags[ctrl.way];

    // last refill beat completes the line
    assign fill_done = ctrl.fill && (ctrl.beat == offset_t'(`DC_BURST_LEN - 1));

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
            plru_q  <= '0;
        end else begin
            if (fill_done) begin
                valid_q[idx][ctrl.way] <= 1'b1;
                dirty_q[idx][ctrl.way] <= 1'b0;
                plru_q[idx]            <= ~ctrl.way;
            end else if (hit && (ctrl.mode == MODE_IDLE)) begin
                // point away from the way just used
                plru_q[idx] <= ~hit_way;
            end
            if (store_hit) begin
                dirty_q[idx][hit_way] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/cache_array.sv ====
`default_nettype none

module cache_array #(
    parameter type elem_t = logic [31:0],
    parameter int  depth  = 16
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] waddr,
    input  elem_t                    wdata,
    input  logic [$clog2(depth)-1:0] raddr,
    output elem_t                    rdata
);

    elem_t mem [depth];

    // whole-element write at the edge
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read path is combinational
    assign rdata = mem[raddr];

endmodule

`default_nettype wire

// ==== source/dcache_pkg.sv ====
`default_nettype none

`include "dcache_macros.svh"

package dcache_pkg;

    typedef logic [8*`DC_WORD_BYTES-1:0] word_t;
    typedef logic [`DC_WORD_BYTES-1:0]   strobe_t;
    typedef logic [`DC_TAG_BITS-1:0]     tag_t;
    typedef logic [`DC_INDEX_BITS-1:0]   index_t;
    typedef logic [`DC_OFFSET_BITS-1:0]  offset_t;
    typedef logic [`DC_WAY_BITS-1:0]     way_t;

    // byte address as the cache splits it
    typedef struct packed {
        tag_t                      tag;
        index_t                    index;
        offset_t                   offset;
        logic [`DC_ALIGN_BITS-1:0] align;
    } addr_t;

    // word slot in the data array
    typedef struct packed {
        way_t    way;
        index_t  index;
        offset_t offset;
    } data_addr_t;

    // one tag per way for each set
    typedef tag_t [`DC_WAYS-1:0] tag_pair_t;

    typedef struct packed {
        logic    valid;
        addr_t   addr;
        strobe_t strobe;
        word_t   data;
    } dbus_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        word_t data;
    } dbus_resp_t;

    typedef struct packed {
        logic  valid;
        logic  is_write;
        addr_t addr;
        word_t data;
    } cbus_req_t;

    typedef struct packed {
        logic  ready;
        logic  last;
        word_t data;
    } cbus_resp_t;

    typedef enum logic [1:0] {
        MODE_IDLE,
        MODE_WRITEBACK,
        MODE_FETCH
    } mode_t;

    typedef struct packed {
        mode_t   mode;
        way_t    way;
        offset_t beat;
        logic    fill;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== source/dcache_macros.svh ====
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// cache geometry
`define DC_WAYS        2
`define DC_SETS        128
`define DC_LINE_WORDS  16
`define DC_ADDR_BITS   32

// a burst always moves one whole line
`define DC_BURST_LEN   `DC_LINE_WORDS

// bytes in one data word
`define DC_WORD_BYTES  4

// derived field widths
`define DC_ALIGN_BITS  $clog2(`DC_WORD_BYTES)
`define DC_OFFSET_BITS $clog2(`DC_LINE_WORDS)
`define DC_INDEX_BITS  $clog2(`DC_SETS)
`define DC_WAY_BITS    $clog2(`DC_WAYS)
`define DC_TAG_BITS    (`DC_ADDR_BITS - `DC_INDEX_BITS - `DC_OFFSET_BITS - `DC_ALIGN_BITS)

`endif
